/* hw/ex_decode.sv */
`timescale 1ns/1ps

module ex_decode
	import insn_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  id_ctrl_t  id_ctrl,
	input  logic      id_freeze,
	input  logic      ex_freeze,
	input  logic      wb_freeze,
	input  logic      flush,
	output ex_ctrl_t  ex_ctrl,
	output insn_t     ex_insn,
	output insn_t     wb_insn,
	output reg_addr_t wb_rfaddrw
);

	insn_t    id_insn;
	opcode_t  id_op;
	alu_op_t  alu_sub;
	logic     bubble;
	ex_ctrl_t ex_next;
	ex_ctrl_t bubble_ctrl;

	assign id_insn = id_ctrl.insn;
	assign id_op   = id_insn[31:26];
	assign alu_sub = id_insn[4:0];

	// id stalled while ex moves on, or the pipe is killed
	assign bubble = (!ex_freeze && id_freeze) || flush;

	//////////////////////////////////////////////////
	// decode of the id instruction into ex controls

	always_comb begin
		ex_next           = EX_CTRL_IDLE;
		ex_next.alu_op2   = id_insn[9:6];
		ex_next.comp_op   = id_insn[24:21];
		ex_next.rf_addrw  = id_insn[25:21];
		ex_next.branch_op = id_ctrl.branch_op;
		ex_next.simm      = id_ctrl.simm;
		// l.sys and l.trap share the xsync opcode
		ex_next.syscall   = (id_insn[31:23] == {OP_XSYNC, 3'b000});
		ex_next.trap      = (id_insn[31:23] == {OP_XSYNC, 3'b010});

		case (id_op)
			OP_J, OP_BNF, OP_BF, OP_NOP, OP_XSYNC, OP_RFE, OP_JR,
			OP_SW, OP_SB, OP_SH: ;
			OP_JAL, OP_JALR: begin
				ex_next.rfwb_op  = {RFWB_LR, 1'b1};
				ex_next.rf_addrw = LINK_REG;
			end
			OP_MOVHI: begin
				ex_next.alu_op  = ALU_MOVHI;
				ex_next.rfwb_op = {RFWB_ALU, 1'b1};
			end
			OP_ADDI: begin
				ex_next.alu_op  = ALU_ADD;
				ex_next.rfwb_op = {RFWB_ALU, 1'b1};
			end
			OP_ADDIC: begin
				ex_next.alu_op  = ALU_ADDC;
				ex_next.rfwb_op = {RFWB_ALU, 1'b1};
			end
			OP_ANDI: begin
				ex_next.alu_op  = ALU_AND;
				ex_next.rfwb_op = {RFWB_ALU, 1'b1};
			end
			OP_ORI: begin
				ex_next.alu_op  = ALU_OR;
				ex_next.rfwb_op = {RFWB_ALU, 1'b1};
			end
			OP_XORI: begin
				ex_next.alu_op  = ALU_XOR;
				ex_next.rfwb_op = {RFWB_ALU, 1'b1};
			end
			OP_ALU: begin
				ex_next.alu_op  = {1'b0, id_insn[3:0]};
				ex_next.rfwb_op = {RFWB_ALU, 1'b1};
				// no multiplier or divider in this core
				ex_next.illegal = (alu_sub == ALU_DIV) || (alu_sub == ALU_DIVU) ||
					(alu_sub == ALU_MUL);
			end
			OP_SFXX, OP_SFXXI: ex_next.alu_op = ALU_COMP;
			OP_MFSPR: begin
				ex_next.spr_read = 1'b1;
				ex_next.rfwb_op  = {RFWB_SPRS, 1'b1};
			end
			OP_MTSPR: ex_next.spr_write = 1'b1;
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				ex_next.rfwb_op = {RFWB_LSU, 1'b1};
			default: ex_next.illegal = 1'b1;
		endcase
	end

	// immediate keeps flowing unless ex itself is frozen
	always_comb begin
		bubble_ctrl      = EX_CTRL_IDLE;
		bubble_ctrl.simm = ex_freeze ? ex_ctrl.simm : id_ctrl.simm;
	end

	//////////////////////////////////////////////////
	// id -> ex registers

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_insn <= NOP_INSN;
			ex_ctrl <= EX_CTRL_IDLE;
		end else if (bubble) begin
			ex_insn <= NOP_INSN;
			ex_ctrl <= bubble_ctrl;
		end else if (!ex_freeze) begin
			ex_insn <= id_insn;
			ex_ctrl <= ex_next;
		end
	end

	//////////////////////////////////////////////////
	// ex -> wb

	// wb write address feeds the forwarding compare
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_insn    <= NOP_INSN;
			wb_rfaddrw <= 5'd0;
		end else if (!wb_freeze) begin
			wb_insn    <= ex_insn;
			wb_rfaddrw <= ex_ctrl.rf_addrw;
		end
	end

endmodule

/* hw/id_decode.sv */
`timescale 1ns/1ps

module id_decode
	import insn_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  insn_t     if_insn,
	input  logic      id_freeze,
	input  logic      flush,
	output id_ctrl_t  id_ctrl,
	output reg_addr_t rf_addra,
	output reg_addr_t rf_addrb,
	output logic      rf_rda,
	output logic      rf_rdb
);

	insn_t      id_insn;
	branch_op_t id_branch_op;
	logic       id_sel_imm;
	lsu_op_t    id_lsu_op;
	logic [31:0] id_simm;
	opcode_t    if_op;
	opcode_t    id_op;

	assign if_op = if_insn[31:26];
	assign id_op = id_insn[31:26];

	// register file read ports look at the fetched word directly
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];
	assign rf_rda   = if_insn[31];
	assign rf_rdb   = if_insn[30];

	//////////////////////////////////////////////////
	// if -> id latch

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_insn      <= NOP_INSN;
			id_branch_op <= BR_NOP;
			id_sel_imm   <= 1'b0;
		end else if (flush) begin
			id_insn      <= NOP_INSN;
			id_branch_op <= BR_NOP;
			// the nop bubble carries no immediate
			id_sel_imm   <= 1'b0;
		end else if (!id_freeze) begin
			id_insn <= if_insn;

			case (if_op)
				OP_J, OP_JAL: id_branch_op <= BR_J;
				OP_JR, OP_JALR: id_branch_op <= BR_JR;
				OP_BNF: id_branch_op <= BR_BNF;
				OP_BF: id_branch_op <= BR_BF;
				OP_RFE: id_branch_op <= BR_RFE;
				default: id_branch_op <= BR_NOP;
			endcase

			// operand b comes from the register file for these
			case (if_op)
				OP_JALR, OP_JR, OP_RFE, OP_MFSPR, OP_MTSPR, OP_XSYNC,
				OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX, OP_NOP: id_sel_imm <= 1'b0;
				default: id_sel_imm <= 1'b1;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// id stage decode

	always_comb begin
		case (id_op)
			OP_LWZ: id_lsu_op = LSU_LWZ;
			OP_LWS: id_lsu_op = LSU_LWS;
			OP_LBZ: id_lsu_op = LSU_LBZ;
			OP_LBS: id_lsu_op = LSU_LBS;
			OP_LHZ: id_lsu_op = LSU_LHZ;
			OP_LHS: id_lsu_op = LSU_LHS;
			OP_SW: id_lsu_op = LSU_SW;
			OP_SB: id_lsu_op = LSU_SB;
			OP_SH: id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

	// immediate extension
	always_comb begin
		case (id_op)
			OP_ADDI, OP_ADDIC, OP_XORI, OP_SFXXI,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// stores split the offset around rD
			OP_SW, OP_SB, OP_SH:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			OP_MTSPR:
				id_simm = {16'd0, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'd0, id_insn[15:0]};
		endcase
	end

	assign id_ctrl = '{
		insn:      id_insn,
		branch_op: id_branch_op,
		lsu_op:    id_lsu_op,
		simm:      id_simm,
		sel_imm:   id_sel_imm
	};

endmodule

/* hw/insn_ctrl_pkg.sv */
package insn_ctrl_pkg;

	//////////////////////////////////////////////////
	// widths and basic types

	localparam int INSN_W = 32;

	typedef logic [INSN_W-1:0] insn_t;
	typedef logic [4:0]        reg_addr_t;
	typedef logic [5:0]        opcode_t;

	//////////////////////////////////////////////////
	// major opcodes, bits 31:26

	localparam opcode_t OP_J      = 6'h00;
	localparam opcode_t OP_JAL    = 6'h01;
	localparam opcode_t OP_BNF    = 6'h03;
	localparam opcode_t OP_BF     = 6'h04;
	localparam opcode_t OP_NOP    = 6'h05;
	localparam opcode_t OP_MOVHI  = 6'h06;
	localparam opcode_t OP_XSYNC  = 6'h08;
	localparam opcode_t OP_RFE    = 6'h09;
	localparam opcode_t OP_JR     = 6'h11;
	localparam opcode_t OP_JALR   = 6'h12;
	localparam opcode_t OP_LWZ    = 6'h21;
	localparam opcode_t OP_LWS    = 6'h22;
	localparam opcode_t OP_LBZ    = 6'h23;
	localparam opcode_t OP_LBS    = 6'h24;
	localparam opcode_t OP_LHZ    = 6'h25;
	localparam opcode_t OP_LHS    = 6'h26;
	localparam opcode_t OP_ADDI   = 6'h27;
	localparam opcode_t OP_ADDIC  = 6'h28;
	localparam opcode_t OP_ANDI   = 6'h29;
	localparam opcode_t OP_ORI    = 6'h2A;
	localparam opcode_t OP_XORI   = 6'h2B;
	localparam opcode_t OP_MFSPR  = 6'h2D;
	localparam opcode_t OP_SFXXI  = 6'h2F;
	localparam opcode_t OP_MTSPR  = 6'h30;
	localparam opcode_t OP_SW     = 6'h35;
	localparam opcode_t OP_SB     = 6'h36;
	localparam opcode_t OP_SH     = 6'h37;
	localparam opcode_t OP_ALU    = 6'h38;
	localparam opcode_t OP_SFXX   = 6'h39;

	// bubble word, l.nop with bit 16 set
	localparam insn_t     NOP_INSN = 32'h1541_0000;
	// r9 takes the return address
	localparam reg_addr_t LINK_REG = 5'd9;

	//////////////////////////////////////////////////
	// encoded operation fields

	typedef logic [2:0] branch_op_t;
	localparam branch_op_t BR_NOP = 3'd0;
	localparam branch_op_t BR_J   = 3'd1;
	localparam branch_op_t BR_JR  = 3'd2;
	localparam branch_op_t BR_BF  = 3'd4;
	localparam branch_op_t BR_BNF = 3'd5;
	localparam branch_op_t BR_RFE = 3'd6;

	typedef logic [4:0] alu_op_t;
	localparam alu_op_t ALU_ADD   = 5'h00;
	localparam alu_op_t ALU_ADDC  = 5'h01;
	localparam alu_op_t ALU_SUB   = 5'h02;
	localparam alu_op_t ALU_AND   = 5'h03;
	localparam alu_op_t ALU_OR    = 5'h04;
	localparam alu_op_t ALU_XOR   = 5'h05;
	localparam alu_op_t ALU_MUL   = 5'h06;
	localparam alu_op_t ALU_SHROT = 5'h08;
	localparam alu_op_t ALU_DIV   = 5'h09;
	localparam alu_op_t ALU_DIVU  = 5'h0A;
	localparam alu_op_t ALU_MOVHI = 5'h10;
	localparam alu_op_t ALU_COMP  = 5'h11;
	localparam alu_op_t ALU_NOP   = 5'h1F;

	// write-back source sits above the write-enable bit
	typedef logic [3:0] rfwb_op_t;
	localparam logic [2:0] RFWB_ALU  = 3'd0;
	localparam logic [2:0] RFWB_LR   = 3'd1;
	localparam logic [2:0] RFWB_SPRS = 3'd2;
	localparam logic [2:0] RFWB_LSU  = 3'd3;
	localparam rfwb_op_t   RFWB_NOP  = 4'd0;

	typedef logic [3:0] lsu_op_t;
	localparam lsu_op_t LSU_NOP = 4'd0;
	localparam lsu_op_t LSU_LWZ = 4'd4;
	localparam lsu_op_t LSU_LWS = 4'd5;
	localparam lsu_op_t LSU_LBZ = 4'd6;
	localparam lsu_op_t LSU_LBS = 4'd7;
	localparam lsu_op_t LSU_LHZ = 4'd8;
	localparam lsu_op_t LSU_LHS = 4'd9;
	localparam lsu_op_t LSU_SW  = 4'd12;
	localparam lsu_op_t LSU_SB  = 4'd13;
	localparam lsu_op_t LSU_SH  = 4'd14;

	typedef logic [1:0] sel_t;
	localparam sel_t SEL_RF      = 2'd0;
	localparam sel_t SEL_IMM     = 2'd1;
	localparam sel_t SEL_EX_FORW = 2'd2;
	localparam sel_t SEL_WB_FORW = 2'd3;

	//////////////////////////////////////////////////
	// stage control bundles

	typedef struct packed {
		insn_t      insn;
		branch_op_t branch_op;
		lsu_op_t    lsu_op;
		logic [31:0] simm;
		logic       sel_imm;
	} id_ctrl_t;

	typedef struct packed {
		alu_op_t    alu_op;
		logic [3:0] alu_op2;
		logic [3:0] comp_op;
		rfwb_op_t   rfwb_op;
		reg_addr_t  rf_addrw;
		branch_op_t branch_op;
		logic [31:0] simm;
		logic       illegal;
		logic       syscall;
		logic       trap;
		logic       spr_read;
		logic       spr_write;
	} ex_ctrl_t;

	// ex stage with nothing in it
	localparam ex_ctrl_t EX_CTRL_IDLE = '{
		alu_op:    ALU_NOP,
		alu_op2:   4'd0,
		comp_op:   4'd0,
		rfwb_op:   RFWB_NOP,
		rf_addrw:  5'd0,
		branch_op: BR_NOP,
		simm:      32'd0,
		illegal:   1'b0,
		syscall:   1'b0,
		trap:      1'b0,
		spr_read:  1'b0,
		spr_write: 1'b0
	};

endpackage

/* hw/insn_ctrl_top.sv */
`timescale 1ns/1ps

module insn_ctrl_top
	import insn_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  insn_t     if_insn,
	input  logic      id_freeze,
	input  logic      ex_freeze,
	input  logic      wb_freeze,
	input  logic      flush,
	input  logic      wbforw_valid,
	output id_ctrl_t  id_ctrl,
	output ex_ctrl_t  ex_ctrl,
	output insn_t     ex_insn,
	output insn_t     wb_insn,
	output reg_addr_t rf_addra,
	output reg_addr_t rf_addrb,
	output logic      rf_rda,
	output logic      rf_rdb,
	output sel_t      sel_a,
	output sel_t      sel_b
);

	reg_addr_t wb_rfaddrw;

	//////////////////////////////////////////////////
	// decode stages

	id_decode id_decode_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.if_insn   (if_insn),
		.id_freeze (id_freeze),
		.flush     (flush),
		.id_ctrl   (id_ctrl),
		.rf_addra  (rf_addra),
		.rf_addrb  (rf_addrb),
		.rf_rda    (rf_rda),
		.rf_rdb    (rf_rdb)
	);

	ex_decode ex_decode_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.id_ctrl    (id_ctrl),
		.id_freeze  (id_freeze),
		.ex_freeze  (ex_freeze),
		.wb_freeze  (wb_freeze),
		.flush      (flush),
		.ex_ctrl    (ex_ctrl),
		.ex_insn    (ex_insn),
		.wb_insn    (wb_insn),
		.wb_rfaddrw (wb_rfaddrw)
	);

	// operand mux selects from both stages
	operand_forward operand_forward_inst (
		.id_ctrl      (id_ctrl),
		.ex_ctrl      (ex_ctrl),
		.wb_rfaddrw   (wb_rfaddrw),
		.wbforw_valid (wbforw_valid),
		.sel_a        (sel_a),
		.sel_b        (sel_b)
	);

endmodule

/* hw/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward
	import insn_ctrl_pkg::*;
(
	input  id_ctrl_t  id_ctrl,
	input  ex_ctrl_t  ex_ctrl,
	input  reg_addr_t wb_rfaddrw,
	input  logic      wbforw_valid,
	output sel_t      sel_a,
	output sel_t      sel_b
);

	reg_addr_t src_a;
	reg_addr_t src_b;
	logic      ex_we;

	assign src_a = id_ctrl.insn[20:16];
	assign src_b = id_ctrl.insn[15:11];
	// low bit of rfwb_op is the write enable
	assign ex_we = ex_ctrl.rfwb_op[0];

	// ex result is newer than wb, so it wins
	always_comb begin
		if ((src_a == ex_ctrl.rf_addrw) && ex_we)
			sel_a = SEL_EX_FORW;
		else if ((src_a == wb_rfaddrw) && wbforw_valid)
			sel_a = SEL_WB_FORW;
		else
			sel_a = SEL_RF;
	end

	always_comb begin
		if (id_ctrl.sel_imm)
			sel_b = SEL_IMM;
		else if ((src_b == ex_ctrl.rf_addrw) && ex_we)
			sel_b = SEL_EX_FORW;
		else if ((src_b == wb_rfaddrw) && wbforw_valid)
			sel_b = SEL_WB_FORW;
		else
			sel_b = SEL_RF;
	end

endmodule

/* insn_ctrl.f */
hw/insn_ctrl_pkg.sv
hw/id_decode.sv
hw/ex_decode.sv
hw/operand_forward.sv
hw/insn_ctrl_top.sv
verif/insn_ctrl_properties.sv
verif/insn_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the insn_ctrl testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module insn_ctrl_tb \
	-f insn_ctrl.f --Mdir "$OBJ" -o insn_ctrl_sim
if [ $? -ne 0 ]; then
	echo "verilator compile step failed"
	exit 1
fi

"./$OBJ/insn_ctrl_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
	echo "testbench reported a failure"
	exit 1
fi
if ! grep -qF '*** PASSED ***' "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

/* verif/insn_ctrl_properties.sv */
`timescale 1ns/1ps

module insn_ctrl_properties
	import insn_ctrl_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input logic       kill,
	input insn_t      insn_q,
	input logic       op_idle,
	input logic [2:0] rst_clear
);

	int unsigned fail_count = 0;

	// a killed slot shows up as a nop one edge later
	kill_to_nop: assert property (@(posedge clk) disable iff (!rst_n)
		kill |=> (insn_q == NOP_INSN) && op_idle)
	else begin
		fail_count++;
		$error("killed slot did not turn into a nop");
	end

	// fields that must read zero out of reset
	no_flags_in_reset: assert property (@(posedge clk)
		!rst_n |=> (rst_clear == 3'b000))
	else begin
		fail_count++;
		$error("exception flags set while in reset");
	end

endmodule

/* verif/insn_ctrl_tb.sv */
`timescale 1ns/1ps

module insn_ctrl_tb
	import insn_ctrl_pkg::*;
();

	localparam int N_FREE = 300;
	localparam int N_DIRECTED = 25;
	localparam int N_MIXED = 400;
	localparam int TOTAL_CYCLES = 2 + N_FREE + N_DIRECTED + N_MIXED + 6;
	localparam int WATCHDOG_NS = 30 * TOTAL_CYCLES + 500;
	localparam int OP_COUNT = 34;

	// control vector {id_freeze, ex_freeze, wb_freeze, flush, wbforw_valid}
	localparam logic [4:0] C_RUN = 5'b00000;
	localparam logic [4:0] C_WBV = 5'b00001;
	localparam logic [4:0] C_FLUSH = 5'b00010;
	localparam logic [4:0] C_WBF = 5'b00100;
	localparam logic [4:0] C_EXF = 5'b01000;
	localparam logic [4:0] C_IDF = 5'b10000;

	logic clk = 1'b0;
	logic rst_n;
	insn_t if_insn;
	logic id_freeze, ex_freeze, wb_freeze, flush, wbforw_valid;
	id_ctrl_t id_ctrl;
	ex_ctrl_t ex_ctrl;
	insn_t ex_insn, wb_insn;
	reg_addr_t rf_addra, rf_addrb;
	logic rf_rda, rf_rdb;
	sel_t sel_a, sel_b;

	int seed = 32'hf175d905;
	int unsigned err_count = 0;
	int unsigned assert_fails;
	logic checks_on = 1'b0;
	int unsigned hit_ex = 0, hit_wb = 0, hit_imm = 0;
	int unsigned hit_link = 0, hit_illegal = 0, hit_sys = 0, hit_trap = 0;

	// last five are outside the decoded set
	opcode_t op_table [OP_COUNT] = '{OP_J, OP_JAL, OP_BNF, OP_BF, OP_NOP, OP_MOVHI,
		OP_XSYNC, OP_RFE, OP_JR, OP_JALR, OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ,
		OP_LHS, OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI, OP_MFSPR, OP_SFXXI,
		OP_MTSPR, OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX,
		6'h02, 6'h07, 6'h0A, 6'h1C, 6'h3F};

	// pipeline model
	insn_t m_id_insn, m_ex_insn, m_wb_insn;
	ex_ctrl_t m_ex_ctrl;
	reg_addr_t m_wb_addr;

	insn_ctrl_top insn_ctrl_top_inst (
		.clk(clk), .rst_n(rst_n), .if_insn(if_insn), .id_freeze(id_freeze),
		.ex_freeze(ex_freeze), .wb_freeze(wb_freeze), .flush(flush),
		.wbforw_valid(wbforw_valid), .id_ctrl(id_ctrl), .ex_ctrl(ex_ctrl),
		.ex_insn(ex_insn), .wb_insn(wb_insn), .rf_addra(rf_addra), .rf_addrb(rf_addrb),
		.rf_rda(rf_rda), .rf_rdb(rf_rdb), .sel_a(sel_a), .sel_b(sel_b)
	);

	bind ex_decode insn_ctrl_properties ex_props_inst (
		.clk(clk), .rst_n(rst_n), .kill(bubble), .insn_q(ex_insn),
		.op_idle(ex_ctrl.alu_op == ALU_NOP),
		.rst_clear({ex_ctrl.illegal, ex_ctrl.syscall, ex_ctrl.trap})
	);
	bind id_decode insn_ctrl_properties id_props_inst (
		.clk(clk), .rst_n(rst_n), .kill(flush), .insn_q(id_insn),
		.op_idle((id_branch_op == BR_NOP) && !id_sel_imm), .rst_clear(id_branch_op)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// reference decode

	function automatic ex_ctrl_t idle_ex(input logic [31:0] simm);
		ex_ctrl_t e;
		e = '0;
		e.alu_op = ALU_NOP;
		e.simm = simm;
		return e;
	endfunction

	function automatic id_ctrl_t decode_id(input insn_t w);
		id_ctrl_t d;
		opcode_t op;
		op = w[31:26];
		d.insn = w;
		case (op)
			OP_J, OP_JAL: d.branch_op = BR_J;
			OP_JR, OP_JALR: d.branch_op = BR_JR;
			OP_BF: d.branch_op = BR_BF;
			OP_BNF: d.branch_op = BR_BNF;
			OP_RFE: d.branch_op = BR_RFE;
			default: d.branch_op = BR_NOP;
		endcase
		case (op)
			OP_LWZ: d.lsu_op = LSU_LWZ;
			OP_LWS: d.lsu_op = LSU_LWS;
			OP_LBZ: d.lsu_op = LSU_LBZ;
			OP_LBS: d.lsu_op = LSU_LBS;
			OP_LHZ: d.lsu_op = LSU_LHZ;
			OP_LHS: d.lsu_op = LSU_LHS;
			OP_SW: d.lsu_op = LSU_SW;
			OP_SB: d.lsu_op = LSU_SB;
			OP_SH: d.lsu_op = LSU_SH;
			default: d.lsu_op = LSU_NOP;
		endcase
		if (op inside {OP_ADDI, OP_ADDIC, OP_XORI, OP_SFXXI, OP_LWZ, OP_LWS, OP_LBZ,
				OP_LBS, OP_LHZ, OP_LHS})
			d.simm = {{16{w[15]}}, w[15:0]};
		else if (op inside {OP_SW, OP_SB, OP_SH})
			d.simm = {{16{w[25]}}, w[25:21], w[10:0]};
		else if (op == OP_MTSPR)
			d.simm = {16'd0, w[25:21], w[10:0]};
		else
			d.simm = {16'd0, w[15:0]};
		d.sel_imm = !(op inside {OP_JALR, OP_JR, OP_RFE, OP_MFSPR, OP_MTSPR, OP_XSYNC,
			OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX, OP_NOP});
		return d;
	endfunction

	function automatic ex_ctrl_t decode_ex(input insn_t w);
		ex_ctrl_t e;
		id_ctrl_t d;
		opcode_t op;
		logic listed;
		op = w[31:26];
		d = decode_id(w);
		e = idle_ex(d.simm);
		e.branch_op = d.branch_op;
		e.alu_op2 = w[9:6];
		e.comp_op = w[24:21];
		e.rf_addrw = (op inside {OP_JAL, OP_JALR}) ? LINK_REG : w[25:21];
		e.syscall = (w[31:23] == {OP_XSYNC, 3'b000});
		e.trap = (w[31:23] == {OP_XSYNC, 3'b010});
		e.spr_read = (op == OP_MFSPR);
		e.spr_write = (op == OP_MTSPR);
		case (op)
			OP_MOVHI: e.alu_op = ALU_MOVHI;
			OP_ADDI: e.alu_op = ALU_ADD;
			OP_ADDIC: e.alu_op = ALU_ADDC;
			OP_ANDI: e.alu_op = ALU_AND;
			OP_ORI: e.alu_op = ALU_OR;
			OP_XORI: e.alu_op = ALU_XOR;
			OP_ALU: e.alu_op = {1'b0, w[3:0]};
			OP_SFXX, OP_SFXXI: e.alu_op = ALU_COMP;
			default: e.alu_op = ALU_NOP;
		endcase
		if (op inside {OP_JAL, OP_JALR})
			e.rfwb_op = {RFWB_LR, 1'b1};
		else if (op inside {OP_MOVHI, OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI, OP_ALU})
			e.rfwb_op = {RFWB_ALU, 1'b1};
		else if (op == OP_MFSPR)
			e.rfwb_op = {RFWB_SPRS, 1'b1};
		else if (op inside {OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS})
			e.rfwb_op = {RFWB_LSU, 1'b1};
		listed = op inside {OP_J, OP_JAL, OP_BNF, OP_BF, OP_NOP, OP_MOVHI, OP_XSYNC,
			OP_RFE, OP_JR, OP_JALR, OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS,
			OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI, OP_MFSPR, OP_SFXXI, OP_MTSPR,
			OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX};
		e.illegal = !listed ||
			((op == OP_ALU) && (w[4:0] inside {ALU_MUL, ALU_DIV, ALU_DIVU}));
		return e;
	endfunction

	// newest producer wins, immediate beats both for operand b
	function automatic sel_t forward_sel(input reg_addr_t src, input logic use_imm,
			input ex_ctrl_t ex_c, input reg_addr_t wb_addr, input logic wbv);
		if (use_imm)
			return SEL_IMM;
		if ((src == ex_c.rf_addrw) && ex_c.rfwb_op[0])
			return SEL_EX_FORW;
		if ((src == wb_addr) && wbv)
			return SEL_WB_FORW;
		return SEL_RF;
	endfunction

	function automatic insn_t random_insn(input logic narrow);
		insn_t w;
		int unsigned pick;
		w = $random(seed);
		pick = $unsigned($random(seed)) % OP_COUNT;
		w[31:26] = op_table[pick];
		// few registers so that dependencies are common
		if (narrow) begin
			w[25:24] = 2'b00;
			w[20:19] = 2'b00;
			w[15:14] = 2'b00;
		end
		return w;
	endfunction

	function automatic insn_t make_insn(input opcode_t op, input reg_addr_t rd,
			input reg_addr_t ra, input logic [15:0] low);
		return {op, rd, ra, low};
	endfunction

	//////////////////////////////////////////////////
	// model and checker

	always @(posedge clk) begin
		id_ctrl_t id_now;
		id_now = decode_id(m_id_insn);
		if (!rst_n) begin
			m_id_insn <= NOP_INSN;
			m_ex_insn <= NOP_INSN;
			m_ex_ctrl <= idle_ex(32'd0);
			m_wb_insn <= NOP_INSN;
			m_wb_addr <= 5'd0;
		end else begin
			if (flush)
				m_id_insn <= NOP_INSN;
			else if (!id_freeze)
				m_id_insn <= if_insn;
			if ((!ex_freeze && id_freeze) || flush) begin
				m_ex_insn <= NOP_INSN;
				m_ex_ctrl <= idle_ex(ex_freeze ? m_ex_ctrl.simm : id_now.simm);
			end else if (!ex_freeze) begin
				m_ex_insn <= m_id_insn;
				m_ex_ctrl <= decode_ex(m_id_insn);
			end
			if (!wb_freeze) begin
				m_wb_insn <= m_ex_insn;
				m_wb_addr <= m_ex_ctrl.rf_addrw;
			end
		end
	end

	task automatic check_val(input string name, input logic [127:0] exp_v,
			input logic [127:0] act_v);
		if (act_v !== exp_v) begin
			err_count++;
			$display("FAILED time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, exp_v, act_v);
		end
	endtask

	always @(negedge clk) begin
		id_ctrl_t id_exp;
		sel_t exp_a;
		sel_t exp_b;
		if (checks_on) begin
			id_exp = decode_id(m_id_insn);
			exp_a = forward_sel(m_id_insn[20:16], 1'b0, m_ex_ctrl, m_wb_addr, wbforw_valid);
			exp_b = forward_sel(m_id_insn[15:11], id_exp.sel_imm, m_ex_ctrl, m_wb_addr,
				wbforw_valid);
			check_val("id_ctrl", 128'(id_exp), 128'(id_ctrl));
			check_val("ex_ctrl", 128'(m_ex_ctrl), 128'(ex_ctrl));
			check_val("ex_insn", 128'(m_ex_insn), 128'(ex_insn));
			check_val("wb_insn", 128'(m_wb_insn), 128'(wb_insn));
			check_val("rf_addra", 128'(if_insn[20:16]), 128'(rf_addra));
			check_val("rf_addrb", 128'(if_insn[15:11]), 128'(rf_addrb));
			check_val("rf_rda", 128'(if_insn[31]), 128'(rf_rda));
			check_val("rf_rdb", 128'(if_insn[30]), 128'(rf_rdb));
			check_val("sel_a", 128'(exp_a), 128'(sel_a));
			check_val("sel_b", 128'(exp_b), 128'(sel_b));
			if ((exp_a == SEL_EX_FORW) || (exp_b == SEL_EX_FORW))
				hit_ex++;
			if ((exp_a == SEL_WB_FORW) || (exp_b == SEL_WB_FORW))
				hit_wb++;
			if (exp_b == SEL_IMM)
				hit_imm++;
			if (m_ex_ctrl.rfwb_op == {RFWB_LR, 1'b1})
				hit_link++;
			hit_illegal += m_ex_ctrl.illegal;
			hit_sys += m_ex_ctrl.syscall;
			hit_trap += m_ex_ctrl.trap;
		end
	end

	//////////////////////////////////////////////////
	// stimulus

	task automatic apply_cycle(input insn_t w, input logic [4:0] ctl);
		@(posedge clk);
		if_insn <= w;
		{id_freeze, ex_freeze, wb_freeze, flush, wbforw_valid} <= ctl;
	endtask

	task automatic require_seen(input string what, input int unsigned count);
		if (count == 0) begin
			err_count++;
			$display("case never exercised: %s", what);
		end
	endtask

	initial begin
		int i;
		logic [31:0] r;
		logic [4:0] ctl;
		rst_n <= 1'b0;
		if_insn <= NOP_INSN;
		{id_freeze, ex_freeze, wb_freeze, flush, wbforw_valid} <= C_RUN;
		@(posedge clk);
		checks_on = 1'b1;
		@(posedge clk);
		rst_n <= 1'b1;

		// free-running random stream
		for (i = 0; i < N_FREE; i++)
			apply_cycle(random_insn(1'b0), C_RUN);

		// back-to-back dependent chain
		apply_cycle(make_insn(OP_ADDI, 5'd3, 5'd1, 16'h0005), C_WBV);
		apply_cycle(make_insn(OP_ALU, 5'd4, 5'd3, {5'd3, 11'h000}), C_WBV);
		apply_cycle(make_insn(OP_ALU, 5'd5, 5'd3, {5'd4, 11'h002}), C_WBV);
		apply_cycle(make_insn(OP_ORI, 5'd6, 5'd5, 16'h00ff), C_WBV);
		apply_cycle(make_insn(OP_JAL, 5'd0, 5'd0, 16'h0010), C_RUN);
		apply_cycle(make_insn(OP_ALU, 5'd7, 5'd9, {5'd9, 11'h000}), C_RUN);
		apply_cycle(NOP_INSN, C_WBV);
		// single flush pulse
		apply_cycle(make_insn(OP_ADDI, 5'd2, 5'd2, 16'h0001), C_FLUSH);
		apply_cycle(make_insn(OP_XORI, 5'd3, 5'd2, 16'hffff), C_RUN);
		// id stalled, ex keeps taking bubbles
		repeat (3) apply_cycle(make_insn(OP_ANDI, 5'd1, 5'd3, 16'h0f0f), C_IDF);
		apply_cycle(make_insn(OP_MFSPR, 5'd8, 5'd0, 16'h0011), C_RUN);
		repeat (3) apply_cycle(make_insn(OP_SW, 5'd2, 5'd8, 16'h0004), C_EXF);
		apply_cycle(make_insn(OP_LWZ, 5'd4, 5'd1, 16'h8000), C_RUN);
		repeat (3) apply_cycle(make_insn(OP_MTSPR, 5'd5, 5'd4, 16'h07ff), C_WBF | C_WBV);
		apply_cycle(make_insn(OP_JALR, 5'd0, 5'd0, {5'd9, 11'h000}), C_IDF | C_EXF);
		apply_cycle(make_insn(OP_XSYNC, 5'd0, 5'd0, 16'h0001), C_FLUSH | C_EXF);
		// trap then syscall run through to ex
		apply_cycle(make_insn(OP_XSYNC, 5'b01000, 5'd0, 16'h0000), C_RUN);
		apply_cycle(make_insn(OP_XSYNC, 5'd0, 5'd0, 16'h0002), C_RUN);
		apply_cycle(NOP_INSN, C_RUN);

		// random stream with freezes, flushes and wb forwarding
		for (i = 0; i < N_MIXED; i++) begin
			r = $random(seed);
			ctl[4] = (r[2:0] == 3'd0);
			ctl[3] = (r[6:4] == 3'd0);
			ctl[2] = (r[10:8] == 3'd0);
			ctl[1] = (r[15:12] == 4'd0);
			ctl[0] = r[16];
			apply_cycle(random_insn(1'b1), ctl);
		end
		repeat (4) apply_cycle(NOP_INSN, C_RUN);
		@(negedge clk);

		require_seen("ex forward", hit_ex);
		require_seen("wb forward", hit_wb);
		require_seen("immediate operand", hit_imm);
		require_seen("link register write", hit_link);
		require_seen("illegal instruction", hit_illegal);
		require_seen("syscall", hit_sys);
		require_seen("trap", hit_trap);
		assert_fails = insn_ctrl_top_inst.ex_decode_inst.ex_props_inst.fail_count +
			insn_ctrl_top_inst.id_decode_inst.id_props_inst.fail_count;
		$display("errors: checks %0d, assertions %0d", err_count, assert_fails);
		if ((err_count == 0) && (assert_fails == 0))
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
		$display("*** FAILED ***");
		$finish;
	end

endmodule
